// ==== filelist.f ====
src/log_pkg.sv
src/log_store.sv
src/log_reader_ctrl.sv
src/log_reader_datap.sv
src/log_reader_top.sv
bench/log_reader_tb.sv

// ==== Bender.yml ====
package:
  name: log_reader

sources:
  - src/log_pkg.sv
  - src/log_store.sv
  - src/log_reader_ctrl.sv
  - src/log_reader_datap.sv
  - src/log_reader_top.sv
  - target: test
    files:
      - bench/log_reader_tb.sv

// ==== bench/log_reader_tb.sv ====
`timescale 1ns/1ps

module log_reader_tb;

    localparam int NUM_REQ    = 200;
    localparam int CLK_PERIOD = 40;
    localparam int TIMEOUT_NS = NUM_REQ * 40 * CLK_PERIOD;

    logic                                clk;
    logic                                rst;
    logic                                rx_hdr_val;
    log_pkg::udp_hdr_t                   rx_hdr;
    logic                                rx_hdr_rdy;
    logic                                rx_data_val;
    logic [63:0]                         rx_data;
    logic                                rx_data_rdy;
    logic                                tx_hdr_val;
    log_pkg::udp_hdr_t                   tx_hdr;
    logic                                tx_hdr_rdy;
    logic                                tx_data_val;
    logic [63:0]                         tx_data;
    logic                                tx_last;
    logic                                tx_data_rdy;
    logic                                log_wr_val;
    logic [log_pkg::LOG_DATA_W-1:0]      log_wr_data;

    integer                              seed;
    logic [63:0]                         model_mem [log_pkg::LOG_DEPTH];
    logic [log_pkg::LOG_ADDR_W-1:0]      model_head;
    logic [log_pkg::LOG_ADDR_W:0]        model_count;
    int                                  hdr_errors;
    int                                  data_errors;
    int                                  meta_errors;
    int                                  proto_errors;

    log_reader_top UUT (
         .clk           (clk)
        ,.rst           (rst)
        ,.rx_hdr_val    (rx_hdr_val)
        ,.rx_hdr        (rx_hdr)
        ,.rx_hdr_rdy    (rx_hdr_rdy)
        ,.rx_data_val   (rx_data_val)
        ,.rx_data       (rx_data)
        ,.rx_data_rdy   (rx_data_rdy)
        ,.tx_hdr_val    (tx_hdr_val)
        ,.tx_hdr        (tx_hdr)
        ,.tx_hdr_rdy    (tx_hdr_rdy)
        ,.tx_data_val   (tx_data_val)
        ,.tx_data       (tx_data)
        ,.tx_last       (tx_last)
        ,.tx_data_rdy   (tx_data_rdy)
        ,.log_wr_val    (log_wr_val)
        ,.log_wr_data   (log_wr_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ********************
    // Compare tasks
    // ********************

    task automatic check_hdr(input string name, input log_pkg::udp_hdr_t expected,
                             input log_pkg::udp_hdr_t actual);
        if (actual !== expected) begin
            hdr_errors++;
            $display("[FAIL] %s: expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_data(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            data_errors++;
            $display("[FAIL] %s: expected %h actual %h", name, expected, actual);
        end
        if (tx_last !== 1'b1) begin
            data_errors++;
            $display("%s: tx_last was not high on the data beat", name);
        end
    endtask

    task automatic check_meta(input string name, input log_pkg::log_meta_t expected,
                              input log_pkg::log_meta_t actual);
        if (actual !== expected) begin
            meta_errors++;
            $display("[FAIL] %s: expected head %0d count %0d actual head %0d count %0d",
                     name, expected.head, expected.count, actual.head, actual.count);
        end
    endtask

    task automatic protocol_error(input string msg);
        proto_errors++;
        $display("%s", msg);
    endtask

    // ********************
    // Stimulus
    // ********************

    // Model follows the store: write at head, head wraps, count saturates.
    task automatic append_entries(input int n);
        logic [63:0] d;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            d = {$random(seed), $random(seed)};
            log_wr_val = 1'b1;
            log_wr_data = d;
            model_mem[model_head] = d;
            model_head = model_head + 1'b1;
            if (model_count < log_pkg::LOG_DEPTH) begin
                model_count = model_count + 1'b1;
            end
        end
        @(negedge clk);
        log_wr_val = 1'b0;
    endtask

    task automatic send_hdr(input log_pkg::udp_hdr_t hdr);
        repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        rx_hdr_val = 1'b1;
        rx_hdr = hdr;
        while (!rx_hdr_rdy) @(negedge clk);
        @(negedge clk);
        rx_hdr_val = 1'b0;
    endtask

    task automatic send_data(input logic [63:0] word);
        repeat ($unsigned($random(seed)) % 3) @(negedge clk);
        rx_data_val = 1'b1;
        rx_data = word;
        while (!rx_data_rdy) @(negedge clk);
        @(negedge clk);
        rx_data_val = 1'b0;
    endtask

    task automatic run_request(input int num, input logic force_meta);
        log_pkg::udp_hdr_t  hdr;
        log_pkg::udp_hdr_t  exp_hdr;
        log_pkg::log_req_t  req;
        log_pkg::log_meta_t exp_meta;
        log_pkg::log_meta_t got_meta;
        logic [63:0]        exp_word;
        int                 hdr_dly;
        int                 data_dly;
        int                 lat;
        string              name;

        name = $sformatf("req %0d", num);
        hdr.src_ip = $random(seed);
        hdr.dst_ip = $random(seed);
        hdr.src_port = 16'($random(seed));
        hdr.dst_port = 16'($random(seed));
        hdr.length = 16'($random(seed));
        exp_hdr.src_ip = hdr.dst_ip;
        exp_hdr.dst_ip = hdr.src_ip;
        exp_hdr.src_port = hdr.dst_port;
        exp_hdr.dst_port = hdr.src_port;
        exp_hdr.length = 16'd8;

        req = {$random(seed), $random(seed)};
        if (force_meta) begin
            req.kind = log_pkg::REQ_META;
        end
        exp_meta.head = model_head;
        exp_meta.count = model_count;
        if (req.kind == log_pkg::REQ_META) begin
            exp_word = 64'd0;
            exp_word[20:16] = model_count;
            exp_word[3:0] = model_head;
        end
        else begin
            exp_word = (req.index < model_count) ? model_mem[req.index] : 64'd0;
        end
        hdr_dly = $unsigned($random(seed)) % 4;
        data_dly = $unsigned($random(seed)) % 4;

        send_hdr(hdr);
        send_data(req);

        // First cycle after the data transfer.
        tx_hdr_rdy = (hdr_dly == 0);
        lat = 1;
        while (!tx_hdr_val) begin
            if (tx_data_val) begin
                protocol_error($sformatf("%s: data beat came before the header", name));
            end
            if (rx_hdr_rdy || rx_data_rdy) begin
                protocol_error($sformatf("%s: rx ready high while a request is in flight",
                                         name));
            end
            @(negedge clk);
            lat++;
        end
        if (lat != 3) begin
            protocol_error($sformatf("%s: tx_hdr_val came %0d cycles after the data, not 3",
                                     name, lat));
        end
        repeat (hdr_dly) @(negedge clk);
        tx_hdr_rdy = 1'b1;
        if (!tx_hdr_val) begin
            protocol_error($sformatf("%s: tx_hdr_val dropped while stalled", name));
        end
        check_hdr($sformatf("%s header", name), exp_hdr, tx_hdr);

        @(negedge clk);
        tx_hdr_rdy = 1'b0;
        tx_data_rdy = (data_dly == 0);
        if (tx_hdr_val || !tx_data_val) begin
            protocol_error($sformatf("%s: no single data beat after the header", name));
        end
        repeat (data_dly) @(negedge clk);
        tx_data_rdy = 1'b1;
        if (!tx_data_val) begin
            protocol_error($sformatf("%s: tx_data_val dropped while stalled", name));
        end
        if (rx_hdr_rdy || rx_data_rdy) begin
            protocol_error($sformatf("%s: rx ready high while the response is pending", name));
        end
        check_data($sformatf("%s data", name), exp_word, tx_data);
        if (req.kind == log_pkg::REQ_META) begin
            got_meta.head = tx_data[3:0];
            got_meta.count = tx_data[20:16];
            check_meta($sformatf("%s metadata", name), exp_meta, got_meta);
        end

        @(negedge clk);
        tx_data_rdy = 1'b0;
        if (tx_hdr_val || tx_data_val) begin
            protocol_error($sformatf("%s: extra beat after the response", name));
        end
        if (!rx_hdr_rdy) begin
            protocol_error($sformatf("%s: not ready for a new header after the response",
                                     name));
        end
    endtask

    // ********************
    // Main sequence
    // ********************

    initial begin
        seed = 32'hd5030bb8;
        rst = 1'b1;
        rx_hdr_val = 1'b0;
        rx_hdr = '0;
        rx_data_val = 1'b0;
        rx_data = '0;
        tx_hdr_rdy = 1'b0;
        tx_data_rdy = 1'b0;
        log_wr_val = 1'b0;
        log_wr_data = '0;
        model_head = '0;
        model_count = '0;
        hdr_errors = 0;
        data_errors = 0;
        meta_errors = 0;
        proto_errors = 0;

        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Nothing goes out before a request.
        repeat (3) begin
            @(negedge clk);
            if (tx_hdr_val || tx_data_val) begin
                protocol_error("tx valid raised with no request accepted");
            end
        end

        run_request(0, 1'b1);
        for (int i = 1; i < NUM_REQ; i++) begin
            append_entries($unsigned($random(seed)) % 4);
            run_request(i, 1'b0);
        end

        $display("Errors: header %0d, data %0d, metadata %0d, protocol %0d",
                 hdr_errors, data_errors, meta_errors, proto_errors);
        if (hdr_errors + data_errors + meta_errors + proto_errors == 0) begin
            $display("Simulation completed successfully");
        end
        else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the requests did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== src/log_reader_top.sv ====
`timescale 1ns/1ps

module log_reader_top (
     input  logic                                clk
    ,input  logic                                rst

    ,input  logic                                rx_hdr_val
    ,input  log_pkg::udp_hdr_t                   rx_hdr
    ,output logic                                rx_hdr_rdy

    ,input  logic                                rx_data_val
    ,input  logic [63:0]                         rx_data
    ,output logic                                rx_data_rdy

    ,output logic                                tx_hdr_val
    ,output log_pkg::udp_hdr_t                   tx_hdr
    ,input  logic                                tx_hdr_rdy

    ,output logic                                tx_data_val
    ,output logic [63:0]                         tx_data
    ,output logic                                tx_last
    ,input  logic                                tx_data_rdy

    ,input  logic                                log_wr_val
    ,input  logic [log_pkg::LOG_DATA_W-1:0]      log_wr_data
);

    logic                           store_hdr;
    logic                           store_req;
    logic                           store_resp;
    logic                           rd_meta;
    logic                           rd_req_val;
    logic                           rd_resp_val;
    logic [log_pkg::LOG_ADDR_W-1:0] rd_addr;
    logic [log_pkg::LOG_DATA_W-1:0] rd_resp_data;
    log_pkg::log_meta_t             meta;

    log_store store (
         .clk           (clk)
        ,.rst           (rst)
        ,.log_wr_val    (log_wr_val)
        ,.log_wr_data   (log_wr_data)
        ,.rd_req_val    (rd_req_val)
        ,.rd_addr       (rd_addr)
        ,.rd_resp_val   (rd_resp_val)
        ,.rd_resp_data  (rd_resp_data)
        ,.meta          (meta)
    );

    log_reader_ctrl ctrl (
         .clk           (clk)
        ,.rst           (rst)
        ,.rx_hdr_val    (rx_hdr_val)
        ,.rx_hdr_rdy    (rx_hdr_rdy)
        ,.rx_data_val   (rx_data_val)
        ,.rx_data_rdy   (rx_data_rdy)
        ,.tx_hdr_val    (tx_hdr_val)
        ,.tx_hdr_rdy    (tx_hdr_rdy)
        ,.tx_data_val   (tx_data_val)
        ,.tx_last       (tx_last)
        ,.tx_data_rdy   (tx_data_rdy)
        ,.rd_req_val    (rd_req_val)
        ,.rd_resp_val   (rd_resp_val)
        ,.store_hdr     (store_hdr)
        ,.store_req     (store_req)
        ,.store_resp    (store_resp)
        ,.rd_meta       (rd_meta)
    );

    log_reader_datap datap (
         .clk           (clk)
        ,.rx_hdr        (rx_hdr)
        ,.rx_data       (rx_data)
        ,.store_hdr     (store_hdr)
        ,.store_req     (store_req)
        ,.store_resp    (store_resp)
        ,.rd_resp_val   (rd_resp_val)
        ,.rd_resp_data  (rd_resp_data)
        ,.meta          (meta)
        ,.rd_meta       (rd_meta)
        ,.rd_addr       (rd_addr)
        ,.tx_hdr        (tx_hdr)
        ,.tx_data       (tx_data)
    );

endmodule

// ==== src/log_reader_datap.sv ====
`timescale 1ns/1ps

module log_reader_datap (
     input  logic                                clk

    ,input  log_pkg::udp_hdr_t                   rx_hdr
    ,input  logic [63:0]                         rx_data

    ,input  logic                                store_hdr
    ,input  logic                                store_req
    ,input  logic                                store_resp

    ,input  logic                                rd_resp_val
    ,input  logic [63:0]                         rd_resp_data
    ,input  log_pkg::log_meta_t                  meta

    ,output logic                                rd_meta
    ,output logic [log_pkg::LOG_ADDR_W-1:0]      rd_addr

    ,output log_pkg::udp_hdr_t                   tx_hdr
    ,output logic [63:0]                         tx_data
);

    log_pkg::udp_hdr_t hdr_reg;
    log_pkg::log_req_t req_reg;
    logic [63:0]       resp_reg;
    logic [63:0]       meta_word;

    // ********************
    // Request capture
    // ********************

    always_ff @(posedge clk) begin
        if (store_hdr) begin
            hdr_reg <= rx_hdr;
        end
        if (store_req) begin
            req_reg <= rx_data;
        end
    end

    assign rd_meta = (req_reg.kind == log_pkg::REQ_META);
    assign rd_addr = req_reg.index;

    // Count in bits [20:16], head in bits [3:0].
    assign meta_word = {43'd0, meta.count, 12'd0, meta.head};

    // ********************
    // Response capture
    // ********************

    always_ff @(posedge clk) begin
        if (store_resp) begin
            if (rd_meta) begin
                resp_reg <= meta_word;
            end
            else if (rd_resp_val) begin
                resp_reg <= rd_resp_data;
            end
        end
    end

    // Reply goes back to the sender.
    always_comb begin
        tx_hdr          = hdr_reg;
        tx_hdr.src_ip   = hdr_reg.dst_ip;
        tx_hdr.dst_ip   = hdr_reg.src_ip;
        tx_hdr.src_port = hdr_reg.dst_port;
        tx_hdr.dst_port = hdr_reg.src_port;
        tx_hdr.length   = 16'(log_pkg::LOG_RESP_BYTES);
    end

    assign tx_data = resp_reg;

endmodule

// ==== src/log_reader_ctrl.sv ====
`timescale 1ns/1ps

module log_reader_ctrl (
     input  logic   clk
    ,input  logic   rst

    ,input  logic   rx_hdr_val
    ,output logic   rx_hdr_rdy

    ,input  logic   rx_data_val
    ,output logic   rx_data_rdy

    ,output logic   tx_hdr_val
    ,input  logic   tx_hdr_rdy

    ,output logic   tx_data_val
    ,output logic   tx_last
    ,input  logic   tx_data_rdy

    ,output logic   rd_req_val
    ,input  logic   rd_resp_val

    ,output logic   store_hdr
    ,output logic   store_req
    ,output logic   store_resp

    ,input  logic   rd_meta
);

    typedef enum logic [2:0] {
        READY       = 3'd0,
        STORE_REQ   = 3'd1,
        RD_LOG      = 3'd2,
        SAVE_LOG_RD = 3'd3,
        HDR_OUT     = 3'd4,
        RESP_OUT    = 3'd5
    } state_e;

    state_e state_reg;
    state_e state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= READY;
        end
        else begin
            state_reg <= state_next;
        end
    end

    always_comb begin
        rx_hdr_rdy  = 1'b0;
        rx_data_rdy = 1'b0;
        tx_hdr_val  = 1'b0;
        tx_data_val = 1'b0;
        tx_last     = 1'b0;
        rd_req_val  = 1'b0;
        store_hdr   = 1'b0;
        store_req   = 1'b0;
        store_resp  = 1'b0;

        state_next = state_reg;
        case (state_reg)
            READY: begin
                rx_hdr_rdy = 1'b1;
                store_hdr = rx_hdr_val;
                if (rx_hdr_val) begin
                    state_next = STORE_REQ;
                end
            end
            STORE_REQ: begin
                rx_data_rdy = 1'b1;
                store_req = rx_data_val;
                if (rx_data_val) begin
                    state_next = RD_LOG;
                end
            end
            RD_LOG: begin
                // Metadata comes straight from the store registers.
                rd_req_val = ~rd_meta;
                state_next = SAVE_LOG_RD;
            end
            SAVE_LOG_RD: begin
                store_resp = 1'b1;
                if (rd_meta || rd_resp_val) begin
                    state_next = HDR_OUT;
                end
            end
            HDR_OUT: begin
                tx_hdr_val = 1'b1;
                if (tx_hdr_rdy) begin
                    state_next = RESP_OUT;
                end
            end
            RESP_OUT: begin
                tx_data_val = 1'b1;
                tx_last = 1'b1;
                if (tx_data_rdy) begin
                    state_next = READY;
                end
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

endmodule

// ==== src/log_store.sv ====
`timescale 1ns/1ps

module log_store (
     input  logic                                clk
    ,input  logic                                rst

    ,input  logic                                log_wr_val
    ,input  logic [log_pkg::LOG_DATA_W-1:0]      log_wr_data

    ,input  logic                                rd_req_val
    ,input  logic [log_pkg::LOG_ADDR_W-1:0]      rd_addr

    ,output logic                                rd_resp_val
    ,output logic [log_pkg::LOG_DATA_W-1:0]      rd_resp_data

    ,output log_pkg::log_meta_t                  meta
);

    logic [log_pkg::LOG_DATA_W-1:0] mem [log_pkg::LOG_DEPTH];

    log_pkg::log_meta_t meta_reg;

    assign meta = meta_reg;

    // ********************
    // Entry memory
    // ********************

    always_ff @(posedge clk) begin
        if (log_wr_val) begin
            mem[meta_reg.head] <= log_wr_data;
        end
    end

    // ********************
    // Head and count
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_reg <= '0;
        end
        else if (log_wr_val) begin
            // Head wraps naturally at the index width.
            meta_reg.head <= meta_reg.head + 1'b1;
            if (meta_reg.count < (log_pkg::LOG_ADDR_W + 1)'(log_pkg::LOG_DEPTH)) begin
                meta_reg.count <= meta_reg.count + 1'b1;
            end
        end
    end

    // ********************
    // Read port
    // ********************

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_resp_val <= 1'b0;
        end
        else begin
            rd_resp_val <= rd_req_val;
        end
    end

    // Slots at or above count have never been written.
    always_ff @(posedge clk) begin
        if (rd_req_val) begin
            if ({1'b0, rd_addr} < meta_reg.count) begin
                rd_resp_data <= mem[rd_addr];
            end
            else begin
                rd_resp_data <= '0;
            end
        end
    end

endmodule

// ==== src/log_pkg.sv ====
package log_pkg;

    // ********************
    // Log geometry
    // ********************

    localparam int LOG_DEPTH      = 16;
    localparam int LOG_ADDR_W     = 4;
    localparam int LOG_DATA_W     = 64;
    localparam int LOG_RESP_BYTES = 8;

    // Request kind, carried in the top bit of the request word.
    typedef enum logic {
        REQ_READ = 1'b0,
        REQ_META = 1'b1
    } log_req_kind_e;

    // ********************
    // Stream and log types
    // ********************

    typedef struct packed {
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
    } udp_hdr_t;

    // Overlay of the 64-bit request payload word.
    typedef struct packed {
        log_req_kind_e                        kind;
        logic [LOG_DATA_W-LOG_ADDR_W-2:0]     reserved;
        logic [LOG_ADDR_W-1:0]                index;
    } log_req_t;

    // Head is the next slot to write. Count saturates at LOG_DEPTH.
    typedef struct packed {
        logic [LOG_ADDR_W-1:0] head;
        logic [LOG_ADDR_W:0]   count;
    } log_meta_t;

endpackage
